// File: hdl/mean_pkg.sv
package mean_pkg;

    // ******************************
    // stream formats
    // ******************************

    localparam int ELEM_W    = 26; // element width of the surrounding pipeline.
    localparam int ROW_ELEMS = 4;
    localparam int MAT_ROWS  = 4;

    // one matrix element, also the width of one accumulator.
    typedef logic signed [ELEM_W-1:0] elem_t;

    // element k sits in slice k counted from the lsb end.
    typedef logic [ROW_ELEMS*ELEM_W-1:0] row_t;

    typedef logic [1:0] row_idx_t;

    // ******************************
    // control
    // ******************************

    typedef enum logic [1:0] {
        ST_ACCUM    = 2'd0, // input open, block accumulating.
        ST_CAPTURE  = 2'd1, // one cycle, copy sums to the buffer.
        ST_WAIT_BUF = 2'd2  // block done but previous mean still draining.
    } mean_state_t;

endpackage

// File: hdl/mean_ctrl.sv
`timescale 1ns/1ps

module mean_ctrl
    import mean_pkg::*;
#(
    parameter int LOG2_BLOCK = 7
) (
    input  logic     clk_mean,
    input  logic     rst_n,
    input  logic     in_valid,
    input  logic     buf_full,
    output logic     in_ready,
    output logic     acc_en,
    output logic     acc_clear,
    output row_idx_t row_sel,
    output logic     capture
);

    localparam row_idx_t LAST_ROW = row_idx_t'(MAT_ROWS - 1);

    mean_state_t           state;
    mean_state_t           state_nxt;
    row_idx_t              row_cnt;
    logic [LOG2_BLOCK-1:0] mat_cnt;
    logic                  last_row;
    logic                  last_mat;
    logic                  block_done;

    // ******************************
    // beat handshake
    // ******************************

    assign in_ready = (state == ST_ACCUM);
    assign acc_en   = in_valid && in_ready;
    assign row_sel  = row_cnt;

    assign last_row = (row_cnt == LAST_ROW);
    assign last_mat = &mat_cnt;

    // first beat of a block loads instead of adding.
    assign acc_clear = acc_en && (row_cnt == '0) && (mat_cnt == '0);

    // final beat of the block is accepted in this cycle.
    assign block_done = acc_en && last_row && last_mat;

    // ******************************
    // row and matrix counters
    // ******************************

    always_ff @(posedge clk_mean or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
            mat_cnt <= '0;
        end else if (acc_en) begin
            row_cnt <= row_cnt + 1'b1; // wraps after row 3.
            if (last_row) begin
                mat_cnt <= mat_cnt + 1'b1; // wraps at the block boundary.
            end
        end
    end

    // ******************************
    // state machine
    // ******************************

    always_comb begin
        state_nxt = state;
        case (state)
            ST_ACCUM: begin
                if (block_done) begin
                    // the buffer may still hold the previous mean.
                    state_nxt = buf_full ? ST_WAIT_BUF : ST_CAPTURE;
                end
            end
            ST_WAIT_BUF: begin
                if (!buf_full) begin
                    state_nxt = ST_CAPTURE;
                end
            end
            ST_CAPTURE: begin
                state_nxt = ST_ACCUM;
            end
            default: begin
                state_nxt = ST_ACCUM;
            end
        endcase
    end

    always_ff @(posedge clk_mean or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_ACCUM;
        end else begin
            state <= state_nxt;
        end
    end

    assign capture = (state == ST_CAPTURE); // single cycle by construction.

    // ******************************
    // checks
    // ******************************

    // the buffer flag comes from the output side and must be clear here.
    a_capture_buf_free: assert property (
        @(posedge clk_mean) disable iff (!rst_n)
        capture |-> !buf_full
    );

    a_acc_en_valid: assert property (
        @(posedge clk_mean) disable iff (!rst_n)
        acc_en |-> in_valid
    );

endmodule

// File: hdl/mean_accum_bank.sv
`timescale 1ns/1ps

module mean_accum_bank
    import mean_pkg::*;
#(
    parameter int LOG2_BLOCK = 7
) (
    input  logic     clk_mean,
    input  logic     rst_n,
    input  logic     acc_en,
    input  logic     acc_clear,
    input  row_idx_t row_sel,
    input  row_t     in_row,
    output row_t     acc_row0,
    output row_t     acc_row1,
    output row_t     acc_row2,
    output row_t     acc_row3
);

    elem_t acc     [MAT_ROWS][ROW_ELEMS];
    elem_t in_elem [ROW_ELEMS];
    elem_t in_shift[ROW_ELEMS];
    row_t  acc_rows[MAT_ROWS];

    // ******************************
    // input scaling
    // ******************************

    // each sample is divided before it is summed, so floor happens per sample.
    for (genvar k = 0; k < ROW_ELEMS; k++) begin : g_scale
        assign in_elem[k]  = elem_t'(in_row[k*ELEM_W +: ELEM_W]);
        assign in_shift[k] = in_elem[k] >>> LOG2_BLOCK;
    end

    // ******************************
    // accumulators
    // ******************************

    always_ff @(posedge clk_mean or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < MAT_ROWS; r++) begin
                for (int k = 0; k < ROW_ELEMS; k++) begin
                    acc[r][k] <= '0;
                end
            end
        end else if (acc_en) begin
            for (int r = 0; r < MAT_ROWS; r++) begin
                if (row_sel == row_idx_t'(r)) begin
                    for (int k = 0; k < ROW_ELEMS; k++) begin
                        if (acc_clear) begin
                            acc[r][k] <= in_shift[k]; // new block starts here.
                        end else begin
                            acc[r][k] <= acc[r][k] + in_shift[k]; // wraps at ELEM_W.
                        end
                    end
                end else if (acc_clear) begin
                    for (int k = 0; k < ROW_ELEMS; k++) begin
                        acc[r][k] <= '0; // the other rows of the new block start at zero.
                    end
                end
            end
        end
    end

    // ******************************
    // packing to rows
    // ******************************

    for (genvar r = 0; r < MAT_ROWS; r++) begin : g_row
        for (genvar k = 0; k < ROW_ELEMS; k++) begin : g_elem
            assign acc_rows[r][k*ELEM_W +: ELEM_W] = acc[r][k];
        end
    end

    assign acc_row0 = acc_rows[0];
    assign acc_row1 = acc_rows[1];
    assign acc_row2 = acc_rows[2];
    assign acc_row3 = acc_rows[3];

    // ******************************
    // checks
    // ******************************

    // the controller only restarts a block on an accepted beat.
    a_clear_with_en: assert property (
        @(posedge clk_mean) disable iff (!rst_n)
        acc_clear |-> acc_en
    );

endmodule

// File: hdl/mean_out_buffer.sv
`timescale 1ns/1ps

module mean_out_buffer
    import mean_pkg::*;
(
    input  logic clk_mean,
    input  logic rst_n,
    input  logic capture,
    input  row_t acc_row0,
    input  row_t acc_row1,
    input  row_t acc_row2,
    input  row_t acc_row3,
    input  logic out_ready,
    output logic buf_full,
    output logic out_valid,
    output row_t out_row,
    output logic out_last
);

    localparam row_idx_t LAST_ROW = row_idx_t'(MAT_ROWS - 1);

    row_t     buf_rows[MAT_ROWS];
    row_idx_t rd_idx;
    logic     full;
    logic     beat;
    logic     beat_last;

    // ******************************
    // output handshake
    // ******************************

    assign out_valid = full;
    assign buf_full  = full;
    assign out_row   = buf_rows[rd_idx];
    assign out_last  = full && (rd_idx == LAST_ROW);

    assign beat      = out_valid && out_ready;
    assign beat_last = beat && out_last;

    // ******************************
    // mean storage
    // ******************************

    // one finished mean, written once per block from the accumulators.
    always_ff @(posedge clk_mean) begin
        if (capture) begin
            buf_rows[0] <= acc_row0;
            buf_rows[1] <= acc_row1;
            buf_rows[2] <= acc_row2;
            buf_rows[3] <= acc_row3;
        end
    end

    // ******************************
    // read control
    // ******************************

    always_ff @(posedge clk_mean or negedge rst_n) begin
        if (!rst_n) begin
            full   <= 1'b0;
            rd_idx <= '0;
        end else if (capture) begin
            full   <= 1'b1;
            rd_idx <= '0;
        end else if (beat) begin
            rd_idx <= rd_idx + 1'b1; // back to row 0 after the last beat.
            if (beat_last) begin
                full <= 1'b0;
            end
        end
    end

    // ******************************
    // checks
    // ******************************

    // a stalled beat must be presented unchanged.
    a_stall_stable: assert property (
        @(posedge clk_mean) disable iff (!rst_n)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_row) && $stable(out_last))
    );

endmodule

// File: hdl/matrix_mean_top.sv
`timescale 1ns/1ps

module matrix_mean_top
    import mean_pkg::*;
#(
    parameter int LOG2_BLOCK = 7
) (
    input  logic clk_mean,
    input  logic rst_n,
    input  logic in_valid,
    input  row_t in_row,
    output logic in_ready,
    output logic out_valid,
    output row_t out_row,
    output logic out_last,
    input  logic out_ready
);

    logic     acc_en;
    logic     acc_clear;
    logic     capture;
    logic     buf_full;
    row_idx_t row_sel;
    row_t     acc_row0;
    row_t     acc_row1;
    row_t     acc_row2;
    row_t     acc_row3;

    mean_ctrl #(
        .LOG2_BLOCK (LOG2_BLOCK)
    ) i_ctrl (
        .clk_mean  (clk_mean),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .buf_full  (buf_full),
        .in_ready  (in_ready),
        .acc_en    (acc_en),
        .acc_clear (acc_clear),
        .row_sel   (row_sel),
        .capture   (capture)
    );

    mean_accum_bank #(
        .LOG2_BLOCK (LOG2_BLOCK)
    ) i_accum (
        .clk_mean  (clk_mean),
        .rst_n     (rst_n),
        .acc_en    (acc_en),
        .acc_clear (acc_clear),
        .row_sel   (row_sel),
        .in_row    (in_row),
        .acc_row0  (acc_row0),
        .acc_row1  (acc_row1),
        .acc_row2  (acc_row2),
        .acc_row3  (acc_row3)
    );

    mean_out_buffer i_out_buf (
        .clk_mean  (clk_mean),
        .rst_n     (rst_n),
        .capture   (capture),
        .acc_row0  (acc_row0),
        .acc_row1  (acc_row1),
        .acc_row2  (acc_row2),
        .acc_row3  (acc_row3),
        .out_ready (out_ready),
        .buf_full  (buf_full),
        .out_valid (out_valid),
        .out_row   (out_row),
        .out_last  (out_last)
    );

endmodule

// File: test/tb_matrix_mean.sv
`timescale 1ns/1ps

module tb_matrix_mean
    import mean_pkg::*;
();

    localparam int     LOG2_BLOCK   = 3;
    localparam int     BLOCK_MATS   = 1 << LOG2_BLOCK;
    localparam int     BLOCK_BEATS  = BLOCK_MATS * MAT_ROWS;
    localparam int     CLK_PERIOD   = 10;
    localparam int     TEST_BLOCKS  = 16; // blocks over tests 2 to 5.
    localparam int     STALL_FACTOR = 40;
    localparam int     TIMEOUT_NS   =
        TEST_BLOCKS * (BLOCK_BEATS + MAT_ROWS) * STALL_FACTOR * CLK_PERIOD;
    localparam longint DIV          = longint'(1) << LOG2_BLOCK;
    localparam longint FULL_SCALE   = longint'(1) << ELEM_W;
    localparam longint HALF_SCALE   = FULL_SCALE / 2;
    localparam int     MODE_RANDOM  = 0;
    localparam int     MODE_EXTREME = 1;

    logic clk_mean;
    logic rst_n;
    logic in_valid;
    row_t in_row;
    logic in_ready;
    logic out_valid;
    row_t out_row;
    logic out_last;
    logic out_ready;

    int     seed = 7495;
    longint model_acc[MAT_ROWS][ROW_ELEMS];
    int     model_row;
    int     model_mat;
    row_t   exp_q[$];
    int     out_cnt;
    int     beats_left;
    logic   in_taken;
    logic   prev_stall;
    row_t   prev_row;
    logic   prev_last;
    int     wait_cycles;
    int     err_cnt;
    int     check_cnt;
    int     rows_seen;

    matrix_mean_top #(
        .LOG2_BLOCK (LOG2_BLOCK)
    ) i_dut (
        .clk_mean  (clk_mean),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_row   (out_row),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    initial begin
        clk_mean = 1'b0;
        forever #(CLK_PERIOD / 2) clk_mean = ~clk_mean;
    end

    // ******************************
    // stimulus helpers
    // ******************************

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic logic pct_hit(input int pct);
        logic [31:0] rnd;
        rnd = next_rand();
        return int'(rnd % 32'd100) < pct;
    endfunction

    function automatic elem_t rand_elem(input int mode);
        logic [31:0] rnd;
        elem_t       e;
        rnd = next_rand();
        if (mode == MODE_RANDOM) begin
            e = rnd[ELEM_W-1:0];
        end else begin
            case (rnd[1:0])
                2'd0:    e = {1'b1, {(ELEM_W-1){1'b0}}}; // minus full scale.
                2'd1:    e = '1;
                2'd2:    e = {1'b0, {(ELEM_W-1){1'b1}}}; // plus full scale.
                default: e = elem_t'(-1) - elem_t'(rnd[6:4]);
            endcase
        end
        return e;
    endfunction

    function automatic row_t make_row(input int mode);
        row_t r;
        for (int k = 0; k < ROW_ELEMS; k++) begin
            r[k*ELEM_W +: ELEM_W] = rand_elem(mode);
        end
        return r;
    endfunction

    // ******************************
    // reference model
    // ******************************

    // division rounded toward minus infinity.
    function automatic longint floor_div(input longint v);
        longint q;
        q = v / DIV;
        if ((v % DIV) != 0 && v < 0) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic longint wrap_elem(input longint v);
        longint w;
        w = v & (FULL_SCALE - 1);
        if (w >= HALF_SCALE) begin
            w = w - FULL_SCALE;
        end
        return w;
    endfunction

    task automatic model_accept(input row_t r);
        elem_t  e;
        longint base;
        row_t   exp_row;
        for (int k = 0; k < ROW_ELEMS; k++) begin
            e = r[k*ELEM_W +: ELEM_W];
            base = (model_mat == 0) ? 0 : model_acc[model_row][k]; // every row restarts.
            model_acc[model_row][k] = wrap_elem(base + floor_div(longint'(e)));
        end
        if (model_row == MAT_ROWS - 1) begin
            model_row = 0;
            if (model_mat == BLOCK_MATS - 1) begin
                model_mat = 0;
                for (int i = 0; i < MAT_ROWS; i++) begin
                    for (int k = 0; k < ROW_ELEMS; k++) begin
                        exp_row[k*ELEM_W +: ELEM_W] = model_acc[i][k][ELEM_W-1:0];
                    end
                    exp_q.push_back(exp_row);
                end
            end else begin
                model_mat++;
            end
        end else begin
            model_row++;
        end
    endtask

    // ******************************
    // per-cycle sampling and checks
    // ******************************

    task automatic sample_cycle();
        row_t exp_row;
        logic exp_last;
        if (exp_q.size() > MAT_ROWS) begin
            wait_cycles++; // a finished block is queued behind the buffer.
            check_cnt++;
            if (in_ready) begin
                $display("error at %0t: input open while a finished block waits", $time);
                err_cnt++;
            end
        end
        if (prev_stall) begin
            check_cnt++;
            if (!out_valid) begin
                $display("error at %0t: out_valid dropped during an output stall", $time);
                err_cnt++;
            end else begin
                if (out_row !== prev_row) begin
                    $display("mismatch at %0t: out_row got %h expected %h",
                             $time, out_row, prev_row);
                    err_cnt++;
                end
                if (out_last !== prev_last) begin
                    $display("mismatch at %0t: out_last got %b expected %b",
                             $time, out_last, prev_last);
                    err_cnt++;
                end
            end
        end
        if (in_valid && in_ready) begin
            model_accept(in_row);
            in_taken = 1'b1;
        end
        if (out_valid && out_ready) begin
            check_cnt++;
            if (exp_q.size() == 0) begin
                $display("error at %0t: output beat arrived with no mean pending", $time);
                err_cnt++;
            end else begin
                exp_row  = exp_q.pop_front();
                exp_last = (out_cnt == MAT_ROWS - 1);
                if (out_row !== exp_row) begin
                    $display("mismatch at %0t: out_row got %h expected %h",
                             $time, out_row, exp_row);
                    err_cnt++;
                end
                if (out_last !== exp_last) begin
                    $display("mismatch at %0t: out_last got %b expected %b",
                             $time, out_last, exp_last);
                    err_cnt++;
                end
                rows_seen++;
            end
            out_cnt = (out_cnt + 1) % MAT_ROWS;
        end
        prev_stall = out_valid && !out_ready;
        prev_row   = out_row;
        prev_last  = out_last;
    endtask

    task automatic run_cycle(input int valid_pct, input int ready_pct, input int mode);
        @(negedge clk_mean);
        if (in_taken) begin
            in_valid = 1'b0;
            in_taken = 1'b0;
        end
        if (!in_valid && beats_left > 0 && pct_hit(valid_pct)) begin
            in_row   = make_row(mode); // held until accepted.
            in_valid = 1'b1;
            beats_left--;
        end
        out_ready = pct_hit(ready_pct);
        #1;
        sample_cycle();
    endtask

    task automatic run_test(input int num, input string name, input int blocks,
                            input int valid_pct, input int ready_pct, input int mode,
                            input logic expect_wait);
        int err_before;
        err_before  = err_cnt;
        wait_cycles = 0;
        beats_left  = blocks * BLOCK_BEATS;
        while (beats_left > 0 || (in_valid && !in_taken) || exp_q.size() > 0 || out_valid) begin
            run_cycle(valid_pct, ready_pct, mode);
        end
        if (expect_wait && wait_cycles == 0) begin
            $display("error: no finished block ever had to wait for the output buffer");
            err_cnt++;
        end
        $display("test %0d %s finished with %0d errors", num, name, err_cnt - err_before);
    endtask

    // ******************************
    // main sequence
    // ******************************

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_row     = '0;
        out_ready  = 1'b0;
        in_taken   = 1'b0;
        prev_stall = 1'b0;
        prev_row   = '0;
        prev_last  = 1'b0;
        model_row  = 0;
        model_mat  = 0;
        out_cnt    = 0;
        err_cnt    = 0;
        check_cnt  = 0;
        rows_seen  = 0;
        repeat (3) @(posedge clk_mean);
        @(negedge clk_mean);
        rst_n = 1'b1;
        #1;
        check_cnt = check_cnt + 2;
        if (in_ready !== 1'b1) begin
            $display("mismatch at %0t: in_ready got %b expected 1", $time, in_ready);
            err_cnt++;
        end
        if (out_valid !== 1'b0) begin
            $display("mismatch at %0t: out_valid got %b expected 0", $time, out_valid);
            err_cnt++;
        end
        $display("test 1 reset state finished with %0d errors", err_cnt);
        run_test(2, "single random block", 1, 100, 100, MODE_RANDOM, 1'b0);
        run_test(3, "extreme values", 1, 100, 100, MODE_EXTREME, 1'b0);
        run_test(4, "input gaps", 8, 50, 100, MODE_RANDOM, 1'b0);
        run_test(5, "output back-pressure", 6, 100, 6, MODE_RANDOM, 1'b1);
        $display("checks %0d, output rows %0d, errors %0d", check_cnt, rows_seen, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns with the tests still running", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: filelist.f
hdl/mean_pkg.sv
hdl/mean_ctrl.sv
hdl/mean_accum_bank.sv
hdl/mean_out_buffer.sv
hdl/matrix_mean_top.sv
test/tb_matrix_mean.sv

// File: run.sh
#!/bin/sh
# builds the matrix mean testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_matrix_mean \
    -Mdir obj_dir \
    -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_matrix_mean)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run only counts as passed when the testbench says so.
if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
